/* verilog/aes_bridge_pkg.sv */
// constants, enums and GF(2^8) arithmetic shared by the AES bridge
// the sbox is computed from the field inverse, so it folds into a 256-entry lookup
`default_nettype none

package aes_bridge_pkg;

	localparam logic [31:0] bridge_addr = 32'h0000_0510;	// data write and cipher read register
	localparam int block_bytes = 16;	// bytes per key or per block
	localparam int num_rounds = 10;	// aes-128

	// sequencer states
	typedef enum logic [2:0]
	{
		collect_key,	// host bytes go to the key fifo
		collect_text,	// host bytes go to the text fifo
		load,	// both fifos stream into the core
		encrypt,	// core running rounds
		drain	// host reads cipher bytes
	} bridge_state_e;

	// read response codes
	typedef enum logic [1:0]
	{
		resp_okay = 2'd0,
		resp_slverr = 2'd2
	} resp_e;

	//--------------------------------------------------------------------------
	// GF(2^8) helpers, polynomial x^8 + x^4 + x^3 + x + 1
	//--------------------------------------------------------------------------
	function automatic logic [7:0] gf_xtime(input logic [7:0] a);
		return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);	// multiply by x
	endfunction

	function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
		logic [7:0] p;
		logic [7:0] t;
		p = 8'h00;
		t = a;
		for (int i = 0; i < 8; i++)
		begin
			if (b[i])
				p = p ^ t;
			t = gf_xtime(t);
		end
		return p;
	endfunction

	// inverse is a^254, built from an addition chain; 0 maps to 0 on its own
	function automatic logic [7:0] sbox(input logic [7:0] a);
		logic [7:0] x2;
		logic [7:0] x3;
		logic [7:0] x12;
		logic [7:0] t;
		logic [7:0] inv;
		x2 = gf_mul(a, a);
		x3 = gf_mul(x2, a);
		x12 = gf_mul(x3, x3);	// x^6
		x12 = gf_mul(x12, x12);	// x^12
		t = gf_mul(x12, x3);	// x^15
		for (int i = 0; i < 4; i++)
			t = gf_mul(t, t);	// ends at x^240
		inv = gf_mul(gf_mul(t, x12), x2);	// x^254
		// affine map: xor of four left rotations, then 0x63
		return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
			^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
	endfunction

endpackage

`default_nettype wire

/* verilog/byte_fifo.sv */
// synchronous fifo with first-word fall-through, head shown on dout with no read latency
// a write when full or a pop when empty is ignored; full and empty are registered
`timescale 1ns/1ps
`default_nettype none

module byte_fifo #(
	parameter int data_width = 8,
	parameter int fifo_depth = 16
)
(
	input logic clk_main_a0,
	input logic rst_main_n_sync,
	input logic wr_en,
	input logic [data_width-1:0] din,
	input logic rd_en,
	output logic [data_width-1:0] dout,
	output logic full,
	output logic empty
);

	localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
	localparam int cnt_w = $clog2(fifo_depth + 1);

	logic [data_width-1:0] mem [fifo_depth];	// circular buffer
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;	// occupancy
	logic [cnt_w-1:0] count_next;
	logic do_wr;
	logic do_rd;

	// wraps at fifo_depth, so depth need not be a power of two
	function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
		return (p == ptr_w'(fifo_depth - 1)) ? '0 : p + 1'b1;
	endfunction

	assign do_wr = wr_en & ~full;
	assign do_rd = rd_en & ~empty;
	assign dout = mem[rd_ptr];	// fall-through head

	always_comb
	begin
		count_next = count;
		if (do_wr & ~do_rd)
			count_next = count + 1'b1;
		else if (do_rd & ~do_wr)
			count_next = count - 1'b1;
	end

	always_ff @(posedge clk_main_a0)
	begin
		if (do_wr)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk_main_a0)
	begin
		if (!rst_main_n_sync)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			full <= 1'b0;
			empty <= 1'b1;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_rd)
				rd_ptr <= ptr_inc(rd_ptr);	// dout moves on this same edge
			count <= count_next;
			full <= (count_next == cnt_w'(fifo_depth));
			empty <= (count_next == '0);
		end
	end

endmodule

`default_nettype wire

/* verilog/aes_round.sv */
// one combinational aes encryption round
// byte 0 of the state is bits 127:120, bytes fill the state column by column
`timescale 1ns/1ps
`default_nettype none

module aes_round (
	input logic [127:0] state_in,
	input logic [127:0] round_key,
	input logic last_round,	// final round skips mixcolumns
	output logic [127:0] state_out
);

	logic [7:0] sb [16];	// after subbytes
	logic [7:0] sr [16];	// after shiftrows
	logic [7:0] mc [16];	// after mixcolumns
	logic [127:0] mixed;

	always_comb
	begin
		for (int i = 0; i < 16; i++)
			sb[i] = aes_bridge_pkg::sbox(state_in[127 - 8*i -: 8]);

		// row r rotates left by r columns
		for (int c = 0; c < 4; c++)
			for (int r = 0; r < 4; r++)
				sr[4*c + r] = sb[4*((c + r) % 4) + r];

		// each output byte is 2*a[r] ^ 3*a[r+1] ^ a[r+2] ^ a[r+3]
		for (int c = 0; c < 4; c++)
			for (int r = 0; r < 4; r++)
				mc[4*c + r] = aes_bridge_pkg::gf_xtime(sr[4*c + r])
					^ aes_bridge_pkg::gf_xtime(sr[4*c + (r + 1) % 4])
					^ sr[4*c + (r + 1) % 4]
					^ sr[4*c + (r + 2) % 4]
					^ sr[4*c + (r + 3) % 4];

		for (int i = 0; i < 16; i++)
			mixed[127 - 8*i -: 8] = last_round ? sr[i] : mc[i];
	end

	assign state_out = mixed ^ round_key;	// addroundkey

endmodule

`default_nettype wire

/* verilog/aes_key_schedule.sv */
// aes-128 key expansion, one round key per step
// round_key is the key that follows the registered one, ready in the same cycle
`timescale 1ns/1ps
`default_nettype none

module aes_key_schedule (
	input logic clk_main_a0,
	input logic rst_main_n_sync,
	input logic [127:0] load_key,
	input logic load,	// take the cipher key
	input logic step,	// advance one round
	output logic [127:0] round_key
);

	logic [127:0] key_q;	// current round key
	logic [7:0] rcon;	// round constant
	logic [31:0] w3_rot;
	logic [31:0] temp;

	assign w3_rot = {key_q[23:0], key_q[31:24]};	// rotword of the last word
	assign temp = {aes_bridge_pkg::sbox(w3_rot[31:24]) ^ rcon,
		aes_bridge_pkg::sbox(w3_rot[23:16]),
		aes_bridge_pkg::sbox(w3_rot[15:8]),
		aes_bridge_pkg::sbox(w3_rot[7:0])};

	// each word chains off the word before it
	assign round_key[127:96] = key_q[127:96] ^ temp;
	assign round_key[95:64] = key_q[95:64] ^ round_key[127:96];
	assign round_key[63:32] = key_q[63:32] ^ round_key[95:64];
	assign round_key[31:0] = key_q[31:0] ^ round_key[63:32];

	always_ff @(posedge clk_main_a0)
	begin
		if (load)
			key_q <= load_key;
		else if (step)
			key_q <= round_key;
	end

	always_ff @(posedge clk_main_a0)
	begin
		if (!rst_main_n_sync || load)
			rcon <= 8'h01;
		else if (step)
			rcon <= aes_bridge_pkg::gf_xtime(rcon);	// doubles in GF(2^8)
	end

endmodule

`default_nettype wire

/* verilog/aes_cipher_core.sv */
// byte-serial aes-128 encryptor: 16 load cycles, 10 round cycles, 16 unload cycles
// load_valid is ignored until done; the first output byte follows the last load by 11 cycles
`timescale 1ns/1ps
`default_nettype none

module aes_cipher_core (
	input logic clk_main_a0,
	input logic rst_main_n_sync,
	input logic load_valid,
	input logic [7:0] key_byte,
	input logic [7:0] text_byte,
	output logic out_valid,
	output logic [7:0] out_byte,
	output logic done	// with the last out byte
);

	localparam int byte_w = $clog2(aes_bridge_pkg::block_bytes);
	localparam int round_w = $clog2(aes_bridge_pkg::num_rounds + 1);

	typedef enum logic [1:0]
	{
		core_idle,	// waiting for or taking load bytes
		core_round,	// one round per clock
		core_out	// shifting ciphertext out
	} core_phase_e;

	core_phase_e phase;
	logic [byte_w-1:0] byte_cnt;	// load and unload position
	logic [round_w-1:0] round_cnt;	// 1 .. num_rounds
	logic [127:0] key_sr;
	logic [127:0] state_q;	// plaintext shifter, then cipher state
	logic [127:0] key_next;
	logic [127:0] text_next;
	logic [127:0] round_key;
	logic [127:0] round_out;
	logic last_byte;
	logic last_round;

	assign key_next = {key_sr[119:0], key_byte};	// msb first
	assign text_next = {state_q[119:0], text_byte};
	assign last_byte = load_valid && (phase == core_idle)
		&& (byte_cnt == byte_w'(aes_bridge_pkg::block_bytes - 1));
	assign last_round = (round_cnt == round_w'(aes_bridge_pkg::num_rounds));

	aes_key_schedule i_key_schedule (
		.clk_main_a0 (clk_main_a0),
		.rst_main_n_sync (rst_main_n_sync),
		.load_key (key_next),
		.load (last_byte),
		.step (phase == core_round),
		.round_key (round_key)
	);

	aes_round i_round (
		.state_in (state_q),
		.round_key (round_key),
		.last_round (last_round),
		.state_out (round_out)
	);

	assign out_valid = (phase == core_out);
	assign out_byte = state_q[127:120];
	assign done = out_valid && (byte_cnt == byte_w'(aes_bridge_pkg::block_bytes - 1));

	//--------------------------------------------------------------------------
	// control
	//--------------------------------------------------------------------------
	always_ff @(posedge clk_main_a0)
	begin
		if (!rst_main_n_sync)
		begin
			phase <= core_idle;
			byte_cnt <= '0;
			round_cnt <= '0;
		end
		else
		begin
			case (phase)
			core_idle:
				if (load_valid)
				begin
					byte_cnt <= byte_cnt + 1'b1;	// wraps to 0 after the 16th
					if (last_byte)
					begin
						phase <= core_round;
						round_cnt <= round_w'(1);
					end
				end
			core_round:
			begin
				round_cnt <= round_cnt + 1'b1;
				if (last_round)
					phase <= core_out;
			end
			core_out:
			begin
				byte_cnt <= byte_cnt + 1'b1;
				if (done)
					phase <= core_idle;
			end
			default: phase <= core_idle;
			endcase
		end
	end

	// datapath
	always_ff @(posedge clk_main_a0)
	begin
		if (load_valid && phase == core_idle)
		begin
			key_sr <= key_next;
			state_q <= last_byte ? (text_next ^ key_next) : text_next;	// initial addroundkey
		end
		else if (phase == core_round)
			state_q <= round_out;
		else if (phase == core_out)
			state_q <= {state_q[119:0], 8'h00};
	end

endmodule

`default_nettype wire

/* verilog/bridge_sequencer.sv */
// write decode, fifo steering and the read response channel of the bridge
// host writes have no back-pressure: writes outside collection or to a full fifo are lost
`timescale 1ns/1ps
`default_nettype none

module bridge_sequencer #(
	parameter int fifo_depth = 16	// at least block_bytes
)
(
	input logic clk_main_a0,
	input logic rst_main_n_sync,
	input logic wr_en,
	input logic [31:0] wr_addr,
	input logic [31:0] wdata,
	input logic arvalid,
	input logic [31:0] araddr,
	input logic rready,
	output logic arready,
	output logic rvalid,
	output logic [31:0] rdata,
	output aes_bridge_pkg::resp_e rresp,
	output logic key_wr_en,
	output logic text_wr_en,
	output logic [7:0] wr_byte,
	input logic key_empty,
	input logic key_full,
	input logic text_empty,
	input logic text_full,
	output logic feed_en,	// pops both fifos, load_valid of the core
	input logic done,
	output logic cipher_rd_en,
	input logic cipher_empty,
	input logic [7:0] cipher_byte
);

	localparam int cnt_w = $clog2(fifo_depth);
	localparam logic [cnt_w-1:0] last_cnt = cnt_w'(aes_bridge_pkg::block_bytes - 1);

	aes_bridge_pkg::bridge_state_e state;
	logic [cnt_w-1:0] byte_cnt;	// feed bytes in load, okay reads in drain
	logic collecting;
	logic wr_hit;
	logic ar_fire;
	logic rd_hit;
	logic r_ok_fire;

	//--------------------------------------------------------------------------
	// write side
	//--------------------------------------------------------------------------
	assign collecting = (state == aes_bridge_pkg::collect_key)
		|| (state == aes_bridge_pkg::collect_text);
	assign wr_hit = wr_en && (wr_addr == aes_bridge_pkg::bridge_addr) && collecting;
	assign key_wr_en = wr_hit && !key_full;
	assign text_wr_en = wr_hit && key_full && !text_full;	// key fifo fills first
	assign wr_byte = wdata[7:0];	// low byte only

	assign feed_en = (state == aes_bridge_pkg::load) && !key_empty && !text_empty;

	//--------------------------------------------------------------------------
	// read side
	//--------------------------------------------------------------------------
	assign arready = (state == aes_bridge_pkg::drain) && !cipher_empty && !rvalid;
	assign ar_fire = arvalid && arready;
	assign rd_hit = (araddr == aes_bridge_pkg::bridge_addr);
	assign cipher_rd_en = ar_fire && rd_hit;	// bad address pops nothing
	assign r_ok_fire = rvalid && rready && (rresp == aes_bridge_pkg::resp_okay);

	always_ff @(posedge clk_main_a0)
	begin
		if (!rst_main_n_sync)
		begin
			rvalid <= 1'b0;
			rdata <= 32'h0;
			rresp <= aes_bridge_pkg::resp_okay;
		end
		else if (ar_fire)
		begin
			rvalid <= 1'b1;
			rdata <= rd_hit ? {24'h0, cipher_byte} : 32'h0;
			rresp <= rd_hit ? aes_bridge_pkg::resp_okay : aes_bridge_pkg::resp_slverr;
		end
		else if (rvalid && rready)
			rvalid <= 1'b0;	// rdata and rresp hold until the next accept
	end

	//--------------------------------------------------------------------------
	// fsm
	//--------------------------------------------------------------------------
	always_ff @(posedge clk_main_a0)
	begin
		if (!rst_main_n_sync)
		begin
			state <= aes_bridge_pkg::collect_key;
			byte_cnt <= '0;
		end
		else
		begin
			case (state)
			aes_bridge_pkg::collect_key:
				if (key_full)
					state <= aes_bridge_pkg::collect_text;
			aes_bridge_pkg::collect_text:
				if (text_full)
					state <= aes_bridge_pkg::load;
			aes_bridge_pkg::load:
				if (feed_en)
				begin
					byte_cnt <= (byte_cnt == last_cnt) ? '0 : byte_cnt + 1'b1;
					if (byte_cnt == last_cnt)
						state <= aes_bridge_pkg::encrypt;	// core starts on its 16th byte
				end
			aes_bridge_pkg::encrypt:
				if (done)
					state <= aes_bridge_pkg::drain;	// all 16 cipher bytes are in the fifo
			aes_bridge_pkg::drain:
				if (r_ok_fire)
				begin
					byte_cnt <= (byte_cnt == last_cnt) ? '0 : byte_cnt + 1'b1;
					if (byte_cnt == last_cnt)
						state <= aes_bridge_pkg::collect_key;
				end
			default: state <= aes_bridge_pkg::collect_key;
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/aes_bridge_top.sv */
// byte-wide register bridge around an aes-128 encryptor
// host writes 16 key then 16 text bytes to bridge_addr, then reads 16 cipher bytes back
`timescale 1ns/1ps
`default_nettype none

module aes_bridge_top #(
	parameter int data_width = 8,
	parameter int fifo_depth = 16	// at least block_bytes
)
(
	input logic clk_main_a0,
	input logic rst_main_n_sync,
	input logic wr_en,
	input logic [31:0] wr_addr,
	input logic [31:0] wdata,
	input logic arvalid,
	input logic [31:0] araddr,
	input logic rready,
	output logic arready,
	output logic rvalid,
	output logic [31:0] rdata,
	output aes_bridge_pkg::resp_e rresp
);

	logic key_wr_en;
	logic text_wr_en;
	logic [data_width-1:0] wr_byte;
	logic [data_width-1:0] key_dout;
	logic [data_width-1:0] text_dout;
	logic key_empty;
	logic key_full;
	logic text_empty;
	logic text_full;
	logic feed_en;
	logic out_valid;	// cipher fifo write
	logic [data_width-1:0] out_byte;
	logic done;
	logic cipher_rd_en;
	logic [data_width-1:0] cipher_dout;
	logic cipher_empty;

	bridge_sequencer #(.fifo_depth (fifo_depth)) i_sequencer (
		.clk_main_a0 (clk_main_a0), .rst_main_n_sync (rst_main_n_sync),
		.wr_en (wr_en), .wr_addr (wr_addr), .wdata (wdata),
		.arvalid (arvalid), .araddr (araddr), .rready (rready),
		.arready (arready), .rvalid (rvalid), .rdata (rdata), .rresp (rresp),
		.key_wr_en (key_wr_en), .text_wr_en (text_wr_en), .wr_byte (wr_byte),
		.key_empty (key_empty), .key_full (key_full),
		.text_empty (text_empty), .text_full (text_full),
		.feed_en (feed_en), .done (done),
		.cipher_rd_en (cipher_rd_en), .cipher_empty (cipher_empty),
		.cipher_byte (cipher_dout)
	);

	// key and text fifos pop together on feed_en
	byte_fifo #(.data_width (data_width), .fifo_depth (fifo_depth)) i_key_fifo (
		.clk_main_a0 (clk_main_a0), .rst_main_n_sync (rst_main_n_sync),
		.wr_en (key_wr_en), .din (wr_byte), .rd_en (feed_en),
		.dout (key_dout), .full (key_full), .empty (key_empty)
	);

	byte_fifo #(.data_width (data_width), .fifo_depth (fifo_depth)) i_text_fifo (
		.clk_main_a0 (clk_main_a0), .rst_main_n_sync (rst_main_n_sync),
		.wr_en (text_wr_en), .din (wr_byte), .rd_en (feed_en),
		.dout (text_dout), .full (text_full), .empty (text_empty)
	);

	// holds one block at most, so its full flag goes unused
	byte_fifo #(.data_width (data_width), .fifo_depth (fifo_depth)) i_cipher_fifo (
		.clk_main_a0 (clk_main_a0), .rst_main_n_sync (rst_main_n_sync),
		.wr_en (out_valid), .din (out_byte), .rd_en (cipher_rd_en),
		.dout (cipher_dout), .full (), .empty (cipher_empty)
	);

	aes_cipher_core i_core (
		.clk_main_a0 (clk_main_a0), .rst_main_n_sync (rst_main_n_sync),
		.load_valid (feed_en), .key_byte (key_dout), .text_byte (text_dout),
		.out_valid (out_valid), .out_byte (out_byte), .done (done)
	);

endmodule

`default_nettype wire

/* tb/aes_bridge_checker.sv */
// read channel assertions, bound into aes_bridge_top
// all properties are off while rst_main_n_sync is low
`timescale 1ns/1ps
`default_nettype none

module aes_bridge_checker (
	input logic clk_main_a0,
	input logic rst_main_n_sync,
	input logic arready,
	input logic rvalid,
	input logic rready,
	input logic [31:0] rdata,
	input logic [1:0] rresp
);

	int fail_count = 0;	// read back by the testbench

	// a response waiting on the host must not move
	a_resp_held: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
	else
	begin
		$error("read response changed while rready was low");
		fail_count++;
	end

	a_no_accept_busy: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
		!(arready && rvalid))
	else
	begin
		$error("arready high while a response is pending");
		fail_count++;
	end

	// only okay and slverr exist
	a_resp_legal: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
		rvalid |-> (rresp == 2'd0 || rresp == 2'd2))
	else
	begin
		$error("rresp carries an undefined code");
		fail_count++;
	end

endmodule

bind aes_bridge_top aes_bridge_checker i_checker (
	.clk_main_a0 (clk_main_a0), .rst_main_n_sync (rst_main_n_sync),
	.arready (arready), .rvalid (rvalid), .rready (rready),
	.rdata (rdata), .rresp (rresp)
);

`default_nettype wire

/* tb/aes_bridge_tb.sv */
// self-checking testbench for the aes bridge that runs 12 blocks through write, encrypt and read
// expected cipher bytes come from a software aes-128 model with its own s-box table
`timescale 1ns/1ps
`default_nettype none

module aes_bridge_tb;

	localparam logic [31:0] data_addr = 32'h0000_0510;	// bridge register
	localparam logic [1:0] resp_ok = 2'd0;
	localparam logic [1:0] resp_err = 2'd2;
	localparam int reset_cycles = 16;
	localparam int num_blocks = 12;
	// 32 writes and about 60 cycles of load and rounds, then 16 reads of up to 10 cycles each
	localparam int block_cycles = 300;
	localparam int cycle_limit = block_cycles * num_blocks + reset_cycles;

	localparam logic [127:0] std_key = 128'h000102030405060708090a0b0c0d0e0f;
	localparam logic [127:0] std_pt = 128'h00112233445566778899aabbccddeeff;
	localparam logic [127:0] std_ct = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

	logic clk_main_a0;
	logic rst_main_n_sync;
	logic wr_en;
	logic [31:0] wr_addr;
	logic [31:0] wdata;
	logic arvalid;
	logic [31:0] araddr;
	logic rready;
	logic arready;
	logic rvalid;
	logic [31:0] rdata;
	logic [1:0] rresp;

	integer seed;
	int cycle_cnt = 0;
	int err_count = 0;
	int check_count = 0;
	int test_errs = 0;	// err_count when the current test began
	logic [7:0] sbox_tab [256];
	logic [31:0] exp_data_q [$];	// one entry per outstanding read
	logic [1:0] exp_resp_q [$];
	logic [31:0] exp_d;
	logic [1:0] exp_r;
	logic [127:0] key;
	logic [127:0] pt;

	aes_bridge_top i_aes_bridge_top (
		.clk_main_a0 (clk_main_a0), .rst_main_n_sync (rst_main_n_sync),
		.wr_en (wr_en), .wr_addr (wr_addr), .wdata (wdata),
		.arvalid (arvalid), .araddr (araddr), .rready (rready),
		.arready (arready), .rvalid (rvalid), .rdata (rdata), .rresp (rresp)
	);

	initial
	begin
		clk_main_a0 = 1'b0;
		forever #10 clk_main_a0 = ~clk_main_a0;	// 20 ns period
	end

	//----------------------------------------------------------------------------
	// reference model
	//----------------------------------------------------------------------------
	function automatic logic [7:0] xt(input logic [7:0] a);
		return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
	endfunction

	function automatic logic [7:0] gmul(input logic [7:0] a, input logic [7:0] b);
		logic [7:0] p;
		logic [7:0] aa;
		logic [7:0] bb;
		p = 8'h00;
		aa = a;
		bb = b;
		while (bb != 8'h00)
		begin
			if (bb[0])
				p = p ^ aa;
			aa = xt(aa);
			bb = bb >> 1;
		end
		return p;
	endfunction

	// inverse by search, then the affine map in its bitwise form
	task automatic fill_sbox();
		logic [7:0] inv;
		logic [7:0] s;
		for (int b = 0; b < 256; b++)
		begin
			inv = 8'h00;	// zero maps to zero
			for (int x = 1; x < 256; x++)
				if (gmul(8'(b), 8'(x)) == 8'h01)
					inv = 8'(x);
			for (int i = 0; i < 8; i++)
				s[i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8]
					^ inv[(i + 6) % 8] ^ inv[(i + 7) % 8];
			sbox_tab[b] = s ^ 8'h63;
		end
	endtask

	function automatic logic [127:0] aes128_ref(input logic [127:0] k, input logic [127:0] p);
		logic [31:0] w [44];	// expanded key words
		logic [31:0] t;
		logic [7:0] rc;
		logic [7:0] s [16];
		logic [7:0] u [16];
		logic [127:0] ct;
		rc = 8'h01;
		for (int i = 0; i < 4; i++)
			w[i] = k[127 - 32*i -: 32];
		for (int i = 4; i < 44; i++)
		begin
			t = w[i - 1];
			if (i % 4 == 0)
			begin
				t = {sbox_tab[t[23:16]] ^ rc, sbox_tab[t[15:8]], sbox_tab[t[7:0]],
					sbox_tab[t[31:24]]};
				rc = xt(rc);
			end
			w[i] = w[i - 4] ^ t;
		end
		for (int i = 0; i < 16; i++)
			s[i] = p[127 - 8*i -: 8] ^ w[i / 4][31 - 8*(i % 4) -: 8];
		for (int r = 1; r <= 10; r++)
		begin
			for (int i = 0; i < 16; i++)
				u[i] = sbox_tab[s[(i + 4*(i % 4)) % 16]];	// subbytes and shiftrows
			for (int c = 0; c < 4; c++)
			begin
				if (r < 10)
				begin
					s[4*c] = xt(u[4*c]) ^ xt(u[4*c+1]) ^ u[4*c+1] ^ u[4*c+2] ^ u[4*c+3];
					s[4*c+1] = u[4*c] ^ xt(u[4*c+1]) ^ xt(u[4*c+2]) ^ u[4*c+2] ^ u[4*c+3];
					s[4*c+2] = u[4*c] ^ u[4*c+1] ^ xt(u[4*c+2]) ^ xt(u[4*c+3]) ^ u[4*c+3];
					s[4*c+3] = xt(u[4*c]) ^ u[4*c] ^ u[4*c+1] ^ u[4*c+2] ^ xt(u[4*c+3]);
				end
				else
				begin
					for (int j = 0; j < 4; j++)
						s[4*c+j] = u[4*c+j];	// last round has no mixcolumns
				end
			end
			for (int i = 0; i < 16; i++)
				s[i] = s[i] ^ w[4*r + i/4][31 - 8*(i % 4) -: 8];
		end
		for (int i = 0; i < 16; i++)
			ct[127 - 8*i -: 8] = s[i];
		return ct;
	endfunction

	//----------------------------------------------------------------------------
	// host side tasks that all start and end 2 ns after a rising edge
	//----------------------------------------------------------------------------
	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		$display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		err_count++;
	endtask

	task automatic drive_write(input logic [31:0] addr, input logic [31:0] data);
		wr_en = 1'b1;
		wr_addr = addr;
		wdata = data;
		@(negedge clk_main_a0);
		check_count++;
		if (arready !== 1'b0 || rvalid !== 1'b0)	// no block ready while collecting
		begin
			$display("at %0t ns arready or rvalid was high during the write phase", $time);
			err_count++;
		end
		@(posedge clk_main_a0);
		#2;
		wr_en = 1'b0;
	endtask

	// msb first with noise in the upper wdata bits
	task automatic write_bytes(input logic [127:0] bytes, input bit stray);
		logic [31:0] junk_addr;
		logic [31:0] rnd;
		for (int i = 0; i < 16; i++)
		begin
			rnd = $random(seed);
			if (stray && rnd[0])
			begin
				junk_addr = $random(seed);
				if (junk_addr == data_addr)
					junk_addr = data_addr + 32'h4;
				drive_write(junk_addr, $random(seed));
			end
			drive_write(data_addr, {rnd[31:8], bytes[127 - 8*i -: 8]});
		end
	endtask

	task automatic read_byte(input logic [31:0] addr, input int stall);
		logic [31:0] exp_rdata;	// queued by the caller for this read
		exp_rdata = exp_data_q[exp_data_q.size() - 1];
		arvalid = 1'b1;
		araddr = addr;
		@(negedge clk_main_a0);
		while (!arready)	// waits out load and rounds on the first read
			@(negedge clk_main_a0);
		@(posedge clk_main_a0);
		#2;
		arvalid = 1'b0;
		@(negedge clk_main_a0);
		check_count++;
		if (rvalid !== 1'b1)
		begin
			$display("at %0t ns rvalid did not rise one cycle after the accept", $time);
			err_count++;
		end
		repeat (stall)
		begin
			@(negedge clk_main_a0);
			check_count++;
			if (rvalid !== 1'b1)
				report_mismatch("rvalid", 32'h1, {31'h0, rvalid});
			if (rdata !== exp_rdata)
				report_mismatch("rdata", exp_rdata, rdata);	// must hold without rready
		end
		@(posedge clk_main_a0);
		#2;
		rready = 1'b1;
		@(posedge clk_main_a0);
		#2;
		rready = 1'b0;
	endtask

	// 16 okay reads, plus one bad-address read before okay read bad_at
	task automatic read_block(input logic [127:0] ct, input int bad_at, input int stall_max);
		int stall;
		for (int i = 0; i < 16; i++)
		begin
			if (i == bad_at)
			begin
				exp_data_q.push_back(32'h0);
				exp_resp_q.push_back(resp_err);
				read_byte(data_addr + 32'h8, 0);
			end
			stall = $unsigned($random(seed)) % (stall_max + 1);
			exp_data_q.push_back({24'h0, ct[127 - 8*i -: 8]});
			exp_resp_q.push_back(resp_ok);
			read_byte(data_addr, stall);
		end
	endtask

	task automatic run_block(input logic [127:0] k, input logic [127:0] p, input bit stray,
		input int bad_at, input int stall_max);
		write_bytes(k, stray);
		write_bytes(p, stray);
		read_block(aes128_ref(k, p), bad_at, stall_max);
	endtask

	task automatic end_test(input int num, input string name);
		if (err_count == test_errs)
			$display("test %0d %s: ok", num, name);
		else
			$display("test %0d %s: %0d errors", num, name, err_count - test_errs);
		test_errs = err_count;
	endtask

	// compare every completed read against the queued expectation
	always @(negedge clk_main_a0)
	begin
		if (rst_main_n_sync && rvalid && rready)
		begin
			if (exp_data_q.size() == 0)
			begin
				$display("at %0t ns a read completed with no read outstanding", $time);
				err_count++;
			end
			else
			begin
				exp_d = exp_data_q.pop_front();
				exp_r = exp_resp_q.pop_front();
				check_count++;
				if (rresp !== exp_r)
					report_mismatch("rresp", {30'h0, exp_r}, {30'h0, rresp});
				if (rdata !== exp_d)
					report_mismatch("rdata", exp_d, rdata);
			end
		end
	end

	always @(posedge clk_main_a0)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit)
		begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Test failed");
			$finish;
		end
	end

	//----------------------------------------------------------------------------
	// test sequence
	//----------------------------------------------------------------------------
	initial
	begin
		seed = 27;
		rst_main_n_sync = 1'b0;
		wr_en = 1'b0;
		wr_addr = 32'h0;
		wdata = 32'h0;
		arvalid = 1'b0;
		araddr = 32'h0;
		rready = 1'b0;
		fill_sbox();
		if (aes128_ref(std_key, std_pt) !== std_ct)
		begin
			$display("the reference model does not reproduce the FIPS-197 vector");
			err_count++;
		end
		repeat (reset_cycles) @(posedge clk_main_a0);
		#2;
		rst_main_n_sync = 1'b1;

		@(negedge clk_main_a0);
		check_count++;
		if (arready !== 1'b0)
			report_mismatch("arready", 32'h0, {31'h0, arready});
		if (rvalid !== 1'b0)
			report_mismatch("rvalid", 32'h0, {31'h0, rvalid});
		@(posedge clk_main_a0);
		#2;
		write_bytes(std_key, 1'b0);
		write_bytes(std_pt, 1'b0);
		end_test(1, "quiet read channel after reset and during writes");

		read_block(std_ct, -1, 0);
		end_test(2, "standard vector");

		for (int b = 0; b < 8; b++)
		begin
			key = {$random(seed), $random(seed), $random(seed), $random(seed)};
			pt = {$random(seed), $random(seed), $random(seed), $random(seed)};
			run_block(key, pt, 1'b0, -1, 0);
		end
		end_test(3, "eight random blocks");

		key = {$random(seed), $random(seed), $random(seed), $random(seed)};
		pt = {$random(seed), $random(seed), $random(seed), $random(seed)};
		run_block(key, pt, 1'b1, -1, 0);
		end_test(4, "writes to other addresses");

		key = {$random(seed), $random(seed), $random(seed), $random(seed)};
		pt = {$random(seed), $random(seed), $random(seed), $random(seed)};
		run_block(key, pt, 1'b0, 5, 0);
		end_test(5, "read from a wrong address");

		key = {$random(seed), $random(seed), $random(seed), $random(seed)};
		pt = {$random(seed), $random(seed), $random(seed), $random(seed)};
		run_block(key, pt, 1'b0, -1, 7);
		end_test(6, "rready stalls");

		if (exp_data_q.size() != 0)
		begin
			$display("%0d expected reads never completed", exp_data_q.size());
			err_count++;
		end
		if (i_aes_bridge_top.i_checker.fail_count != 0)
		begin
			$display("%0d read channel assertions failed",
				i_aes_bridge_top.i_checker.fail_count);
			err_count++;
		end
		$display("checks: %0d, errors: %0d", check_count, err_count);
		if (err_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
verilog/aes_bridge_pkg.sv
verilog/byte_fifo.sv
verilog/aes_round.sv
verilog/aes_key_schedule.sv
verilog/aes_cipher_core.sv
verilog/bridge_sequencer.sv
verilog/aes_bridge_top.sv
tb/aes_bridge_checker.sv
tb/aes_bridge_tb.sv

/* Bender.yml */
package:
  name: aes_bridge

sources:
  - verilog/aes_bridge_pkg.sv
  - verilog/byte_fifo.sv
  - verilog/aes_round.sv
  - verilog/aes_key_schedule.sv
  - verilog/aes_cipher_core.sv
  - verilog/bridge_sequencer.sv
  - verilog/aes_bridge_top.sv
  - target: test
    files:
      - tb/aes_bridge_checker.sv
      - tb/aes_bridge_tb.sv
